//--- src.f
rtl/nes_pad_pkg.sv
rtl/nes_bus_pkg.sv
rtl/uart_reg_decoder.sv
rtl/pad_mapper.sv
rtl/mem_access_sequencer.sv
rtl/joypad_shifter.sv
rtl/nes_board_ctrl.sv
verification/tb_nes_board_ctrl.sv

//--- verification/tb_nes_board_ctrl.sv
//****************************************
// self-checking testbench for the NES board glue
// table of pad rows applied in a loop, plus
// loader, autofire and memory sequencing checks
//****************************************
`default_nettype none
`timescale 1ns/10ps

module tb_nes_board_ctrl;
  import nes_pad_pkg::*;
  import nes_bus_pkg::*;

  localparam int          CLK_PERIOD      = 20;
  localparam int          NUM_ROWS        = 13;
  localparam int          WATCHDOG_CYCLES = NUM_ROWS * 60;
  localparam logic [31:0] SEED            = 32'h12fcc1e8;
  localparam ds_report_t  DS_OFF          = 16'hffff;  // all released, active low
  localparam usb_pad_t    USB_OFF         = 10'h000;
  localparam uart_wr_t    NO_WR           = '0;

  // one table row
  typedef struct packed {
    uart_wr_t     uw;
    ds_report_t   ds1;
    ds_report_t   ds2;
    usb_pad_t     usb1;
    usb_pad_t     usb2;
    logic         rnd;   // pad inputs drawn at run time
    nes_buttons_t exp1;
    nes_buttons_t exp2;
  } row_t;

  logic         clk = 1'b0;
  logic         sys_resetn;
  uart_wr_t     uart_wr;
  ds_report_t   ds_p1;
  ds_report_t   ds_p2;
  usb_pad_t     usb_p1;
  usb_pad_t     usb_p2;
  logic         usb_conerr;
  logic         loader_done;
  loader_wr_t   loader_wr;
  nes_mem_req_t nes_req;
  logic         joypad_strobe;
  logic [1:0]   joypad_clock;
  logic [1:0]   joypad_data;
  logic         loader_reset;
  mem_data_t    rom_byte;
  logic         rom_byte_valid;
  logic         run_nes;
  logic         nes_reset;
  mem_cmd_t     mem_cmd;
  logic [1:0]   led;

  row_t         rows [NUM_ROWS];
  logic [31:0]  rng;
  nes_buttons_t host_p1;  // host byte model per player
  nes_buttons_t host_p2;
  int           checks;
  int           errors;

  nes_board_ctrl #(.AUTOFIRE_HALF(32'd4)) i_nes_board_ctrl (
    .clk            (clk),
    .sys_resetn     (sys_resetn),
    .uart_wr        (uart_wr),
    .ds_p1          (ds_p1),
    .ds_p2          (ds_p2),
    .usb_p1         (usb_p1),
    .usb_p2         (usb_p2),
    .usb_conerr     (usb_conerr),
    .loader_done    (loader_done),
    .loader_wr      (loader_wr),
    .nes_req        (nes_req),
    .joypad_strobe  (joypad_strobe),
    .joypad_clock   (joypad_clock),
    .joypad_data    (joypad_data),
    .loader_reset   (loader_reset),
    .rom_byte       (rom_byte),
    .rom_byte_valid (rom_byte_valid),
    .run_nes        (run_nes),
    .nes_reset      (nes_reset),
    .mem_cmd        (mem_cmd),
    .led            (led)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference mapping, NES order right left down up start select b a
  function automatic nes_buttons_t expect_buttons(input ds_report_t ds, input usb_pad_t usb);
    nes_buttons_t b;
    b[7] = !ds.ds_byte0[5];
    b[6] = !ds.ds_byte0[7];
    b[5] = !ds.ds_byte0[6];
    b[4] = !ds.ds_byte0[4];
    b[3] = !ds.ds_byte0[3];
    b[2] = !ds.ds_byte0[0];
    b[1] = !ds.ds_byte1[6];  // cross
    b[0] = !ds.ds_byte1[5];  // circle
    return b | usb.btn;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
  endtask

  task automatic set_row(input int idx, input uart_wr_t uw, input ds_report_t ds1,
                         input ds_report_t ds2, input usb_pad_t usb1, input usb_pad_t usb2,
                         input logic rnd, input nes_buttons_t e1, input nes_buttons_t e2);
    rows[idx] = {uw, ds1, ds2, usb1, usb2, rnd, e1, e2};
  endtask

  // strobe both pads, then eight serial bits, A first
  task automatic read_pads(output nes_buttons_t p1, output nes_buttons_t p2);
    int i;
    p1 = '0;
    p2 = '0;
    @(negedge clk) joypad_strobe = 1'b1;
    @(negedge clk) joypad_strobe = 1'b0;
    for (i = 0; i < 8; i++) begin
      p1[i] = joypad_data[0];
      p2[i] = joypad_data[1];
      joypad_clock = 2'b11;
      @(negedge clk) joypad_clock = 2'b00;
      @(negedge clk);  // shift lands on the edge in between
    end
  endtask

  task automatic apply_row(input int idx);
    row_t         r;
    nes_buttons_t exp1;
    nes_buttons_t exp2;
    nes_buttons_t got1;
    nes_buttons_t got2;
    r = rows[idx];
    if (r.rnd) begin
      // square and triangle stay released, autofire is checked apart
      rng    = xorshift32(rng);
      r.ds1  = rng[15:0] | 16'h0090;
      r.ds2  = rng[31:16] | 16'h0090;
      rng    = xorshift32(rng);
      r.usb1 = {rng[7:0], 2'b00};
      r.usb2 = {rng[15:8], 2'b00};
    end
    @(negedge clk);
    uart_wr = r.uw;
    ds_p1   = r.ds1;
    ds_p2   = r.ds2;
    usb_p1  = r.usb1;
    usb_p2  = r.usb2;
    if (r.uw.write && r.uw.addr == REG_BTN_P1)
      host_p1 = r.uw.data;
    if (r.uw.write && r.uw.addr == REG_BTN_P2)
      host_p2 = r.uw.data;
    @(negedge clk) uart_wr = NO_WR;
    @(negedge clk);
    if (r.rnd) begin
      exp1 = expect_buttons(r.ds1, r.usb1) | host_p1;
      exp2 = expect_buttons(r.ds2, r.usb2) | host_p2;
    end else begin
      exp1 = r.exp1;
      exp2 = r.exp2;
    end
    read_pads(got1, got2);
    check_value($sformatf("row %0d player 1 read", idx), got1, exp1);
    check_value($sformatf("row %0d player 2 read", idx), got2, exp2);
  endtask

  task automatic check_loader_ctrl();
    check_value("loader_reset after release", loader_reset, 0);
    uart_wr = {REG_ROM_DATA, 8'ha5, 1'b1};
    @(negedge clk) uart_wr = NO_WR;
    check_value("rom_byte_valid after write", rom_byte_valid, 1);
    check_value("rom_byte", rom_byte, 8'ha5);
    @(negedge clk);
    check_value("rom_byte_valid single pulse", rom_byte_valid, 0);
    uart_wr = {REG_LOADER_CONF, 8'h01, 1'b1};
    @(negedge clk) uart_wr = NO_WR;
    check_value("loader_reset set by config", loader_reset, 1);
    @(negedge clk);
    check_value("loader_reset held", loader_reset, 1);
    uart_wr = {REG_LOADER_CONF, 8'h00, 1'b1};
    @(negedge clk) uart_wr = NO_WR;
    check_value("loader_reset cleared by config", loader_reset, 0);
  endtask

  task automatic check_autofire();
    int           k;
    logic         seen_set;
    logic         seen_clear;
    nes_buttons_t g1;
    nes_buttons_t g2;
    seen_set   = 1'b0;
    seen_clear = 1'b0;
    @(negedge clk) ds_p1 = 16'hff7f;  // square held
    repeat (2) @(negedge clk);
    for (k = 0; k < 4; k++) begin
      read_pads(g1, g2);
      check_value("autofire only on B", g1 & 8'hfd, 0);
      if (g1[1])
        seen_set = 1'b1;
      else
        seen_clear = 1'b1;
      repeat (8) @(negedge clk);
    end
    check_value("autofire B seen set", seen_set, 1);
    check_value("autofire B seen clear", seen_clear, 1);
    ds_p1 = DS_OFF;
    repeat (2) @(negedge clk);
    read_pads(g1, g2);
    check_value("B clear after release", g1, 0);
    check_value("player 2 idle", g2, 0);
  endtask

  task automatic check_sequencing();
    int   i;
    int   last_run;
    int   run_count;
    logic prev_run;
    logic seen_run;
    logic hold_read;
    prev_run  = 1'b0;
    seen_run  = 1'b0;
    hold_read = 1'b0;
    last_run  = 0;
    run_count = 0;
    loader_done = 1'b1;
    for (i = 0; i < 35; i++) begin
      @(negedge clk);
      if (run_nes) begin
        if (seen_run)
          check_value("run_nes spacing", i - last_run, 5);
        last_run = i;
        run_count++;
      end
      // memory slot is the cycle right after run_nes
      if (seen_run && hold_read) begin
        check_value("read_a only after run_nes", mem_cmd.read_a, prev_run);
        check_value("no refresh during NES read", mem_cmd.refresh, 0);
        if (mem_cmd.read_a)
          check_value("read address", mem_cmd.addr, 22'h012345);
      end else if (seen_run) begin
        check_value("refresh in idle memory slot", mem_cmd.refresh, prev_run);
        check_value("read_a while idle", mem_cmd.read_a, 0);
      end
      check_value("no write without loader", mem_cmd.write, 0);
      check_value("read_b never used", mem_cmd.read_b, 0);
      seen_run = seen_run | run_nes;
      prev_run = run_nes;
      if (i == 19) begin
        nes_req.addr     = 22'h012345;
        nes_req.read_cpu = 1'b1;
        hold_read        = 1'b1;
      end
    end
    check_value("run_nes count in 35 cycles", run_count, 7);
    check_value("nes_reset with loader done", nes_reset, 0);
    check_value("loader_done LED on", led[0], 0);
    check_value("usb error LED off", led[1], 1);
    usb_conerr = 1'b1;
    @(negedge clk);
    check_value("usb error LED on", led[1], 0);
    usb_conerr = 1'b0;
    loader_wr.addr  = 22'h2abcd4;
    loader_wr.data  = 8'h3c;
    loader_wr.write = 1'b1;
    for (i = 0; i < 6; i++) begin
      @(negedge clk);
      check_value("loader write strobe", mem_cmd.write, 1);
      check_value("loader write address", mem_cmd.addr, 22'h2abcd4);
      check_value("loader write data", mem_cmd.din, 8'h3c);
      check_value("NES read blocked by loader", mem_cmd.read_a, 0);
      check_value("no refresh with loader write", mem_cmd.refresh, 0);
    end
    loader_wr = '0;
    nes_req   = '0;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the test did not complete", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    sys_resetn    = 1'b0;
    uart_wr       = NO_WR;
    ds_p1         = DS_OFF;
    ds_p2         = DS_OFF;
    usb_p1        = USB_OFF;
    usb_p2        = USB_OFF;
    usb_conerr    = 1'b0;
    loader_done   = 1'b0;
    loader_wr     = '0;
    nes_req       = '0;
    joypad_strobe = 1'b0;
    joypad_clock  = 2'b00;
    rng           = SEED;
    host_p1       = '0;
    host_p2       = '0;
    checks        = 0;
    errors        = 0;

    set_row(0, {REG_BTN_P1, 8'h5a, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 0, 8'h5a, 8'h00);
    set_row(1, {REG_BTN_P2, 8'hc3, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 0, 8'h5a, 8'hc3);
    set_row(2, {REG_BTN_P1, 8'h00, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 0, 8'h00, 8'hc3);
    set_row(3, {REG_BTN_P2, 8'h00, 1'b1}, 16'hdfff, DS_OFF, USB_OFF, USB_OFF, 0, 8'h80, 8'h00);
    set_row(4, NO_WR, 16'hf6bf, 16'h2fdf, USB_OFF, USB_OFF, 0, 8'h0e, 8'h71);
    set_row(5, NO_WR, DS_OFF, DS_OFF, 10'h204, 10'h090, 0, 8'h81, 8'h24);
    set_row(6, {REG_BTN_P1, 8'h10, 1'b1}, 16'hdfff, DS_OFF, 10'h004, USB_OFF, 0, 8'h91, 8'h00);
    set_row(7, {REG_BTN_P1, 8'h00, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 1, 8'h00, 8'h00);
    set_row(8, {REG_BTN_P2, 8'h02, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 1, 8'h00, 8'h00);
    set_row(9, NO_WR, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 1, 8'h00, 8'h00);
    set_row(10, {REG_BTN_P1, 8'h40, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 1, 8'h00, 8'h00);
    set_row(11, {REG_BTN_P1, 8'h00, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 1, 8'h00, 8'h00);
    set_row(12, {REG_BTN_P2, 8'h00, 1'b1}, DS_OFF, DS_OFF, USB_OFF, USB_OFF, 0, 8'h00, 8'h00);

    repeat (2) @(negedge clk);
    check_value("mem_cmd strobes in reset",
                {mem_cmd.read_a, mem_cmd.read_b, mem_cmd.write, mem_cmd.refresh}, 0);
    check_value("run_nes in reset", run_nes, 0);
    check_value("rom_byte_valid in reset", rom_byte_valid, 0);
    check_value("loader_reset in reset", loader_reset, 1);
    check_value("nes_reset without loader", nes_reset, 1);
    check_value("joypad_data in reset", joypad_data, 0);
    check_value("LEDs dark in reset", led, 2'b11);
    sys_resetn = 1'b1;
    @(negedge clk);

    check_loader_ctrl();
    for (int r = 0; r < NUM_ROWS; r++)
      apply_row(r);
    check_autofire();
    check_sequencing();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/nes_board_ctrl.sv
//**************************************
// board glue around the NES core: UART regs,
// pad mapping and read-out, memory arbitration
// set AUTOFIRE_HALF for the clock in use
//**************************************
`default_nettype none
`timescale 1ns/10ps

module nes_board_ctrl #(
  parameter logic [31:0] AUTOFIRE_HALF = 32'd1_000_000
) (
  input  wire                              clk,
  input  wire                              sys_resetn,
  input  wire nes_bus_pkg::uart_wr_t       uart_wr,
  input  wire nes_pad_pkg::ds_report_t     ds_p1,
  input  wire nes_pad_pkg::ds_report_t     ds_p2,
  input  wire nes_pad_pkg::usb_pad_t       usb_p1,
  input  wire nes_pad_pkg::usb_pad_t       usb_p2,
  input  wire                              usb_conerr,
  input  wire                              loader_done,
  input  wire nes_bus_pkg::loader_wr_t     loader_wr,
  input  wire nes_bus_pkg::nes_mem_req_t   nes_req,
  input  wire                              joypad_strobe,
  input  wire [1:0]                        joypad_clock,
  output logic [1:0]                       joypad_data,
  output logic                             loader_reset,
  output nes_bus_pkg::mem_data_t           rom_byte,
  output logic                             rom_byte_valid,
  output logic                             run_nes,
  output logic                             nes_reset,
  output nes_bus_pkg::mem_cmd_t            mem_cmd,
  output logic [1:0]                       led
);
  import nes_pad_pkg::*;

  nes_buttons_t host_btn_p1;
  nes_buttons_t host_btn_p2;
  nes_buttons_t mapped_p1;
  nes_buttons_t mapped_p2;
  nes_buttons_t load_p1;
  nes_buttons_t load_p2;
  logic         joy_data_p1;
  logic         joy_data_p2;

  uart_reg_decoder i_uart_reg_decoder (
    .clk            (clk),
    .sys_resetn     (sys_resetn),
    .uart_wr        (uart_wr),
    .loader_reset   (loader_reset),
    .host_btn_p1    (host_btn_p1),
    .host_btn_p2    (host_btn_p2),
    .rom_byte       (rom_byte),
    .rom_byte_valid (rom_byte_valid)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) i_pad_mapper_p1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds         (ds_p1),
    .usb        (usb_p1),
    .buttons    (mapped_p1)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) i_pad_mapper_p2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds         (ds_p2),
    .usb        (usb_p2),
    .buttons    (mapped_p2)
  );

  mem_access_sequencer i_mem_access_sequencer (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .loader_done (loader_done),
    .nes_req     (nes_req),
    .loader_wr   (loader_wr),
    .run_nes     (run_nes),
    .nes_reset   (nes_reset),
    .mem_cmd     (mem_cmd)
  );

  // host buttons from the UART act as an extra pad
  assign load_p1 = host_btn_p1 | mapped_p1;
  assign load_p2 = host_btn_p2 | mapped_p2;

  joypad_shifter i_joypad_shifter_p1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .strobe     (joypad_strobe),
    .joy_clk    (joypad_clock[0]),
    .load_value (load_p1),
    .joy_data   (joy_data_p1)
  );

  joypad_shifter i_joypad_shifter_p2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .strobe     (joypad_strobe),
    .joy_clk    (joypad_clock[1]),
    .load_value (load_p2),
    .joy_data   (joy_data_p2)
  );

  assign joypad_data = {joy_data_p2, joy_data_p1};

  assign led = ~{usb_conerr, loader_done};  // LEDs light on low

endmodule

`default_nettype wire

//--- rtl/joypad_shifter.sv
//**************************************
// NES controller shift register, one player
// loads on strobe, shifts on joy_clk fall
//**************************************
`default_nettype none
`timescale 1ns/10ps

module joypad_shifter (
  input  wire                              clk,
  input  wire                              sys_resetn,
  input  wire                              strobe,
  input  wire                              joy_clk,
  input  wire nes_pad_pkg::nes_buttons_t   load_value,
  output logic                             joy_data
);
  import nes_pad_pkg::*;

  nes_buttons_t shift_q;
  logic         joy_clk_q;
  logic         joy_clk_fall;

  assign joy_clk_fall = joy_clk_q && !joy_clk;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q   <= '0;
      joy_clk_q <= 1'b0;
    end else begin
      joy_clk_q <= joy_clk;
      if (strobe)
        shift_q <= load_value;
      if (joy_clk_fall)
        shift_q <= {1'b0, shift_q[7:1]};  // shift wins over load, A goes out first
    end
  end

  assign joy_data = shift_q[0];

  a_joy_data_known: assert property (@(posedge clk) disable iff (!sys_resetn)
    !$isunknown(joy_data))
    else $error("joy_data unknown");

endmodule

`default_nettype wire

//--- rtl/mem_access_sequencer.sv
//**************************************
// five-phase clock enable for memory and
// NES core, and the merged SDRAM command
//**************************************
`default_nettype none
`timescale 1ns/10ps

module mem_access_sequencer (
  input  wire                              clk,
  input  wire                              sys_resetn,
  input  wire                              loader_done,
  input  wire nes_bus_pkg::nes_mem_req_t   nes_req,
  input  wire nes_bus_pkg::loader_wr_t     loader_wr,
  output logic                             run_nes,
  output logic                             nes_reset,
  output nes_bus_pkg::mem_cmd_t            mem_cmd
);
  import nes_bus_pkg::*;

  ce_phase_t phase;
  ce_phase_t phase_next;
  logic      run_mem;
  logic      nes_access;
  logic      nes_cmd;  // NES access passed on this cycle

  //  phase   | 0 | 1 | 2 | 3 | 4 | 0 |
  //  memory  |cmd|   busy        |   |
  //  NES                     |run|
  always_comb begin
    case (phase)
      PH0:     phase_next = PH1;
      PH1:     phase_next = PH2;
      PH2:     phase_next = PH3;
      PH3:     phase_next = PH4;
      default: phase_next = PH0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      phase <= PH0;
    else
      phase <= phase_next;
  end

  assign run_mem   = loader_done && (phase == CE_RUN_MEM);
  assign run_nes   = loader_done && (phase == CE_RUN_NES);
  assign nes_reset = ~loader_done;  // NES waits for the game

  assign nes_access = nes_req.read_cpu | nes_req.read_ppu | nes_req.write;
  assign nes_cmd    = run_mem & nes_access;

  always_comb begin
    mem_cmd = '0;
    if (loader_wr.write) begin
      // loader always wins
      mem_cmd.addr  = loader_wr.addr;
      mem_cmd.din   = loader_wr.data;
      mem_cmd.write = 1'b1;
    end else begin
      mem_cmd.addr    = nes_req.addr;
      mem_cmd.din     = nes_req.dout;
      mem_cmd.read_a  = run_mem & nes_req.read_cpu;
      mem_cmd.read_b  = run_mem & nes_req.read_ppu;
      mem_cmd.write   = run_mem & nes_req.write;
      // idle memory slot or loader asking for it
      mem_cmd.refresh = ~nes_cmd & (run_mem | loader_wr.refresh);
    end
  end

  a_no_write_refresh: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(mem_cmd.write && mem_cmd.refresh))
    else $error("write and refresh issued together");

  // NES reads only land in the memory slot
  a_nes_in_mem_slot: assert property (@(posedge clk) disable iff (!sys_resetn)
    (mem_cmd.read_a || mem_cmd.read_b) |-> run_mem)
    else $error("NES read outside run_mem");

endmodule

`default_nettype wire

//--- rtl/pad_mapper.sv
//**************************************
// maps one player's DualShock and USB pad
// to NES buttons, autofire on B and A
// output is registered, one cycle latency
//**************************************
`default_nettype none
`timescale 1ns/10ps

module pad_mapper #(
  parameter logic [31:0] AUTOFIRE_HALF = 32'd1_000_000  // cycles per autofire half period
) (
  input  wire                            clk,
  input  wire                            sys_resetn,
  input  wire nes_pad_pkg::ds_report_t   ds,
  input  wire nes_pad_pkg::usb_pad_t     usb,
  output nes_pad_pkg::nes_buttons_t      buttons
);
  import nes_pad_pkg::*;

  localparam int AF_B = 0;  // square / usb y
  localparam int AF_A = 1;  // triangle / usb x

  logic [1:0]   af_held;
  logic [1:0]   af_out;
  nes_buttons_t ds_btn;
  nes_buttons_t mapped;

  // dualshock is active low
  assign af_held[AF_B] = ~ds.ds_byte1[DS_SQUARE] | usb.y;
  assign af_held[AF_A] = ~ds.ds_byte1[DS_TRIANGLE] | usb.x;

  for (genvar i = 0; i < 2; i++) begin : g_autofire
    logic [31:0] af_cnt;

    always_ff @(posedge clk) begin
      if (!sys_resetn) begin
        af_cnt    <= '0;
        af_out[i] <= 1'b0;
      end else if (!af_held[i]) begin
        // release clears at once
        af_cnt    <= '0;
        af_out[i] <= 1'b0;
      end else if (af_cnt == AUTOFIRE_HALF - 32'd1) begin
        af_cnt    <= '0;
        af_out[i] <= ~af_out[i];
      end else begin
        af_cnt <= af_cnt + 32'd1;
      end
    end
  end

  // reorder into right left down up start select b a
  assign ds_btn = {
    ~ds.ds_byte0[DS_RIGHT],
    ~ds.ds_byte0[DS_LEFT],
    ~ds.ds_byte0[DS_DOWN],
    ~ds.ds_byte0[DS_UP],
    ~ds.ds_byte0[DS_START],
    ~ds.ds_byte0[DS_SELECT],
    ~ds.ds_byte1[DS_CROSS],
    ~ds.ds_byte1[DS_CIRCLE]
  };

  assign mapped = ds_btn | usb.btn | {6'b0, af_out[AF_B], af_out[AF_A]};

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      buttons <= '0;
    else
      buttons <= mapped;
  end

endmodule

`default_nettype wire

//--- rtl/uart_reg_decoder.sv
//**************************************
// decodes UART register writes into loader
// control, host buttons and ROM bytes
//**************************************
`default_nettype none
`timescale 1ns/10ps

module uart_reg_decoder (
  input  wire                            clk,
  input  wire                            sys_resetn,
  input  wire nes_bus_pkg::uart_wr_t     uart_wr,
  output logic                           loader_reset,
  output nes_pad_pkg::nes_buttons_t      host_btn_p1,
  output nes_pad_pkg::nes_buttons_t      host_btn_p2,
  output nes_bus_pkg::mem_data_t         rom_byte,
  output logic                           rom_byte_valid
);
  import nes_bus_pkg::*;

  logic wr_conf;
  logic wr_rom;
  logic wr_btn_p1;
  logic wr_btn_p2;
  logic conf_loader_rst;  // config bit 0, the only one in use

  assign wr_conf   = uart_wr.write && (uart_wr.addr == REG_LOADER_CONF);
  assign wr_rom    = uart_wr.write && (uart_wr.addr == REG_ROM_DATA);
  assign wr_btn_p1 = uart_wr.write && (uart_wr.addr == REG_BTN_P1);
  assign wr_btn_p2 = uart_wr.write && (uart_wr.addr == REG_BTN_P2);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_loader_rst <= 1'b0;
      loader_reset    <= 1'b1;  // loader held until config is known
      host_btn_p1     <= '0;
      host_btn_p2     <= '0;
      rom_byte_valid  <= 1'b0;
    end else begin
      if (wr_conf)
        conf_loader_rst <= uart_wr.data[0];
      // bypass so the new value shows one cycle after the write
      loader_reset <= wr_conf ? uart_wr.data[0] : conf_loader_rst;
      if (wr_btn_p1)
        host_btn_p1 <= uart_wr.data;
      if (wr_btn_p2)
        host_btn_p2 <= uart_wr.data;
      rom_byte_valid <= wr_rom;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_rom)
      rom_byte <= uart_wr.data;
  end

  // back-to-back valid only for back-to-back ROM writes
  a_rom_valid_single: assert property (@(posedge clk) disable iff (!sys_resetn)
    rom_byte_valid && $past(rom_byte_valid) |-> $past(wr_rom) && $past(wr_rom, 2))
    else $error("rom_byte_valid held without consecutive ROM writes");

endmodule

`default_nettype wire

//--- rtl/nes_bus_pkg.sv
//**************************************
// memory bus, UART register map and the
// clock-enable phases of the NES board glue
//**************************************
`default_nettype none

package nes_bus_pkg;

  typedef logic [21:0] mem_addr_t;  // 4 MB space
  typedef logic [7:0]  mem_data_t;
  typedef logic [7:0]  uart_reg_addr_t;

  // one register write from the UART receiver
  typedef struct packed {
    uart_reg_addr_t addr;
    mem_data_t      data;
    logic           write;  // single-cycle strobe
  } uart_wr_t;

  localparam uart_reg_addr_t REG_LOADER_CONF = 8'h35;
  localparam uart_reg_addr_t REG_ROM_DATA    = 8'h37;
  localparam uart_reg_addr_t REG_BTN_P1      = 8'h40;
  localparam uart_reg_addr_t REG_BTN_P2      = 8'h41;

  // access request from the NES core
  typedef struct packed {
    mem_addr_t addr;
    mem_data_t dout;
    logic      read_cpu;
    logic      read_ppu;
    logic      write;
  } nes_mem_req_t;

  // write port of the game loader
  typedef struct packed {
    mem_addr_t addr;
    mem_data_t data;
    logic      write;
    logic      refresh;
  } loader_wr_t;

  // command to the SDRAM controller
  typedef struct packed {
    mem_addr_t addr;
    mem_data_t din;
    logic      read_a;   // cpu port
    logic      read_b;   // ppu port
    logic      write;
    logic      refresh;
  } mem_cmd_t;

  typedef enum logic [2:0] {PH0, PH1, PH2, PH3, PH4} ce_phase_t;

  localparam ce_phase_t CE_RUN_MEM = PH0;
  localparam ce_phase_t CE_RUN_NES = PH4;

endpackage

`default_nettype wire

//--- rtl/nes_pad_pkg.sv
//**************************************
// controller types for the board glue
// NES pad byte, DualShock report and USB pad
// import where pad state is mapped or shifted
//**************************************
`default_nettype none

package nes_pad_pkg;

  // one NES pad, msb to lsb: right left down up start select b a
  typedef logic [7:0] nes_buttons_t;

  // DualShock button bytes as received, active low
  typedef struct packed {
    logic [7:0] ds_byte0;  // dpad, start, select
    logic [7:0] ds_byte1;  // face buttons
  } ds_report_t;

  // decoded USB gamepad, active high
  typedef struct packed {
    nes_buttons_t btn;  // already in NES order
    logic         x;    // autofire source for A
    logic         y;    // autofire source for B
  } usb_pad_t;

  // ds_byte0 positions
  localparam int unsigned DS_SELECT = 0;
  localparam int unsigned DS_START  = 3;
  localparam int unsigned DS_UP     = 4;
  localparam int unsigned DS_RIGHT  = 5;
  localparam int unsigned DS_DOWN   = 6;
  localparam int unsigned DS_LEFT   = 7;

  // ds_byte1 positions
  localparam int unsigned DS_TRIANGLE = 4;
  localparam int unsigned DS_CIRCLE   = 5;  // plain A
  localparam int unsigned DS_CROSS    = 6;  // plain B
  localparam int unsigned DS_SQUARE   = 7;

endpackage

`default_nettype wire
